//--- tri_mem.f
+incdir+include
hw/tri_mem_load_pkg.sv
hw/tri_mem_geom_pkg.sv
hw/tri_index_ram.sv
hw/vertex_ram.sv
hw/tri_out_buf.sv
hw/tri_mem_ctrl.sv
hw/tri_mem.sv
verification/tri_mem_asserts.sv
verification/tri_mem_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		-f tri_mem.f --top-module tri_mem_tb \
		-Mdir obj_dir -o tri_mem_sim
	./obj_dir/tri_mem_sim

clean:
	rm -rf obj_dir

//--- verification/tri_mem_tb.sv
`timescale 1ns/1ns
`include "tri_mem_macros.svh"

module tri_mem_tb;

    import tri_mem_load_pkg::*;
    import tri_mem_geom_pkg::*;

    localparam int NUM_VTX = 64;
    localparam int NUM_TRI = 16;

    typedef enum logic [1:0] {
        OP_READ,
        OP_LOAD_VTX,
        OP_LOAD_IDX
    } tb_op_t;

    // key names the model triangle and gap counts idle cycles before the row
    typedef struct packed {
        tb_op_t     op;
        vtx_idx_t   addr;
        load_data_t data;
        logic [3:0] key;
        logic [3:0] gap;
    } row_t;

    logic        clk, rst_n, load_req, load_ack, re, rdy;
    load_op_t    load_op;
    vtx_idx_t    load_addr;
    load_data_t  load_data;
    tri_id_t     tri_id;
    vertex_t     vertex0, vertex1, vertex2;
    tag_t        tag;

    vertex_t     model_vtx [NUM_VTX];
    int          model_idx [NUM_TRI][3];
    tag_t        model_tag [NUM_TRI];
    row_t        rows [$];
    logic [31:0] rng;
    int          cycle_limit;
    int          cycle_cnt;

    tri_mem i_tri_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_req  (load_req),
        .load_op   (load_op),
        .load_addr (load_addr),
        .load_data (load_data),
        .load_ack  (load_ack),
        .re        (re),
        .tri_id    (tri_id),
        .rdy       (rdy),
        .vertex0   (vertex0),
        .vertex1   (vertex1),
        .vertex2   (vertex2),
        .tag       (tag)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // step to the drive and sample point after the edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic check_vertex(input string name, input vertex_t got, input vertex_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic add_row(input tb_op_t op, input int addr, input load_data_t data,
                           input int key, input int gap);
        row_t r;
        r.op   = op;
        r.addr = vtx_idx_t'(addr);
        r.data = data;
        r.key  = 4'(key);
        r.gap  = 4'(gap);
        rows.push_back(r);
    endtask

    // four-phase load with ack low before and held up while req is up
    task automatic do_load(input load_op_t op, input vtx_idx_t addr, input load_data_t data);
        check_bit("load_ack", load_ack, 1'b0);
        load_op   = op;
        load_addr = addr;
        load_data = data;
        load_req  = 1'b1;
        next_cycle();
        while (!load_ack)
            next_cycle();
        next_cycle();
        check_bit("load_ack", load_ack, 1'b1);
        load_req = 1'b0;
        next_cycle();
        while (load_ack)
            next_cycle();
    endtask

    task automatic do_read(input tri_id_t id, input int key);
        re     = 1'b1;
        tri_id = id;
        next_cycle();
        re = 1'b0;
        check_bit("rdy", rdy, 1'b0);
        while (!rdy)
            next_cycle();
        check_vertex("vertex0", vertex0, model_vtx[model_idx[key][0]]);
        check_vertex("vertex1", vertex1, model_vtx[model_idx[key][1]]);
        check_vertex("vertex2", vertex2, model_vtx[model_idx[key][2]]);
        check_tag("tag", tag, model_tag[key]);
    endtask

    task automatic build_table();
        // scattered ids
        add_row(OP_READ, 5, '0, 5, 0);
        add_row(OP_READ, 12, '0, 12, 0);
        add_row(OP_READ, 3, '0, 3, 3);
        add_row(OP_READ, 9, '0, 9, 0);
        // consecutive ids hit a finished or running prefetch
        add_row(OP_READ, 0, '0, 0, 10);
        add_row(OP_READ, 1, '0, 1, 10);
        add_row(OP_READ, 2, '0, 2, 2);
        add_row(OP_READ, 3, '0, 3, 10);
        add_row(OP_LOAD_IDX, 5, {32'd10, 32'd20, 32'd30, 32'h7a90_0005}, 5, 0);
        add_row(OP_READ, 5, '0, 5, 0);
        // prefetch of 5 completes, then vertex 20 is rewritten
        add_row(OP_READ, 4, '0, 4, 0);
        add_row(OP_LOAD_VTX, 20, {32'h4120_0000, 32'hc0a0_0000, 32'h3f80_0000, 32'h1}, 0, 10);
        add_row(OP_READ, 5, '0, 5, 0);
        add_row(OP_READ, 6, '0, 6, 10);
        add_row(OP_LOAD_IDX, 7, {32'd20, 32'd33, 32'd41, 32'h7a90_0007}, 7, 2);
        add_row(OP_READ, 7, '0, 7, 0);
        add_row(OP_READ, 15, '0, 15, 0);
        add_row(OP_READ, 14, '0, 14, 8);
    endtask

    initial begin
        cycle_cnt = 0;
        wait (cycle_limit != 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped by the cycle limit");
    end

    initial begin
        row_t        r;
        logic [31:0] w [4];
        int          num_loads;
        rst_n       = 1'b0;
        load_req    = 1'b0;
        load_op     = LOAD_INDEX;
        load_addr   = '0;
        load_data   = '0;
        re          = 1'b0;
        tri_id      = '0;
        rng         = 32'd66433;
        build_table();
        num_loads = NUM_VTX + NUM_TRI;
        foreach (rows[i])
            if (rows[i].op != OP_READ)
                num_loads++;
        cycle_limit = 40 * rows.size() + 200 * num_loads;

        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;
        check_bit("rdy", rdy, 1'b0);
        check_bit("load_ack", load_ack, 1'b0);
        check_vertex("vertex0", vertex0, '0);
        check_vertex("vertex1", vertex1, '0);
        check_vertex("vertex2", vertex2, '0);
        check_tag("tag", tag, '0);

        // random model where the flag lane is loaded but never read back
        for (int v = 0; v < NUM_VTX; v++) begin
            for (int c = 0; c < 4; c++) begin
                rng  = xorshift32(rng);
                w[c] = rng;
            end
            model_vtx[v] = {w[0], w[1], w[2]};
            do_load(LOAD_VERTEX, vtx_idx_t'(v), {w[0], w[1], w[2], w[3]});
        end
        for (int t = 0; t < NUM_TRI; t++) begin
            for (int c = 0; c < 4; c++) begin
                rng  = xorshift32(rng);
                w[c] = rng;
            end
            for (int k = 0; k < 3; k++)
                model_idx[t][k] = int'(w[k] % NUM_VTX);
            model_tag[t] = w[3];
            do_load(LOAD_INDEX, vtx_idx_t'(t), {32'(model_idx[t][0]), 32'(model_idx[t][1]),
                                                32'(model_idx[t][2]), w[3]});
        end

        foreach (rows[i]) begin
            r = rows[i];
            repeat (r.gap)
                next_cycle();
            case (r.op)
                OP_READ: begin
                    do_read(tri_id_t'(r.addr), int'(r.key));
                end
                OP_LOAD_VTX: begin
                    // shift the flag lane out, x y z remain
                    model_vtx[r.addr] = vertex_t'(r.data >> `TRI_WORD_W);
                    do_load(LOAD_VERTEX, r.addr, r.data);
                end
                default: begin
                    for (int k = 0; k < 3; k++)
                        model_idx[r.key][k] =
                            int'(r.data[`TRI_LOAD_W-1-`TRI_WORD_W*k -: `TRI_WORD_W]);
                    model_tag[r.key] = r.data[`TRI_WORD_W-1:0];
                    do_load(LOAD_INDEX, r.addr, r.data);
                end
            endcase
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- verification/tri_mem_asserts.sv
`timescale 1ns/1ns

module tri_mem_asserts (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      load_req,
    input logic                      load_ack,
    input logic                      re,
    input logic                      rdy,
    input tri_mem_geom_pkg::vertex_t vertex0,
    input tri_mem_geom_pkg::vertex_t vertex1,
    input tri_mem_geom_pkg::vertex_t vertex2,
    input tri_mem_geom_pkg::tag_t    tag
);

    // ack only answers a pending request
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(load_ack) |-> load_req)
        else $error("load_ack rose while load_req was low");

    ack_after_req_low: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(load_ack) |-> !$past(load_req))
        else $error("load_ack fell while load_req was still high");

    rdy_drop: assert property (@(posedge clk) disable iff (!rst_n)
        re |=> !rdy)
        else $error("rdy still high in the cycle after re");

    // outputs frozen for the whole rdy window
    out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (rdy && $past(rdy)) |-> $stable({vertex0, vertex1, vertex2, tag}))
        else $error("outputs changed while rdy was high");

endmodule

bind tri_mem tri_mem_asserts i_tri_mem_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .load_req (load_req),
    .load_ack (load_ack),
    .re       (re),
    .rdy      (rdy),
    .vertex0  (vertex0),
    .vertex1  (vertex1),
    .vertex2  (vertex2),
    .tag      (tag)
);

//--- hw/tri_mem.sv
`timescale 1ns/1ns
`include "tri_mem_macros.svh"

module tri_mem (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         load_req,
    input  tri_mem_load_pkg::load_op_t   load_op,
    input  tri_mem_geom_pkg::vtx_idx_t   load_addr,
    input  tri_mem_load_pkg::load_data_t load_data,
    output logic                         load_ack,
    input  logic                         re,
    input  tri_mem_geom_pkg::tri_id_t    tri_id,
    output logic                         rdy,
    output tri_mem_geom_pkg::vertex_t    vertex0,
    output tri_mem_geom_pkg::vertex_t    vertex1,
    output tri_mem_geom_pkg::vertex_t    vertex2,
    output tri_mem_geom_pkg::tag_t       tag
);

    import tri_mem_geom_pkg::*;

    logic                                 idx_we, vtx_we;
    logic [$clog2(`TRI_NUM_TRIANGLE)+1:0] idx_addr;
    tag_t                                 idx_wdata, idx_q;
    vtx_idx_t                             vtx_addr;
    vertex_t                              vtx_wdata, vtx_q;
    logic                                 cap_en, promote;
    buf_sel_t                             cap_slot;
    logic [1:0]                           cap_lane;

    tri_mem_ctrl i_tri_mem_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_req  (load_req),
        .load_op   (load_op),
        .load_addr (load_addr),
        .load_data (load_data),
        .re        (re),
        .tri_id    (tri_id),
        .idx_q     (idx_q),
        .load_ack  (load_ack),
        .rdy       (rdy),
        .idx_we    (idx_we),
        .idx_addr  (idx_addr),
        .idx_wdata (idx_wdata),
        .vtx_we    (vtx_we),
        .vtx_addr  (vtx_addr),
        .vtx_wdata (vtx_wdata),
        .cap_en    (cap_en),
        .cap_slot  (cap_slot),
        .cap_lane  (cap_lane),
        .promote   (promote)
    );

    tri_index_ram i_tri_index_ram (
        .clk   (clk),
        .we    (idx_we),
        .addr  (idx_addr),
        .wdata (idx_wdata),
        .q     (idx_q)
    );

    vertex_ram i_vertex_ram (
        .clk   (clk),
        .we    (vtx_we),
        .addr  (vtx_addr),
        .wdata (vtx_wdata),
        .q     (vtx_q)
    );

    tri_out_buf i_tri_out_buf (
        .clk      (clk),
        .rst_n    (rst_n),
        .cap_en   (cap_en),
        .cap_slot (cap_slot),
        .cap_lane (cap_lane),
        .promote  (promote),
        .vtx_q    (vtx_q),
        .idx_q    (idx_q),
        .vertex0  (vertex0),
        .vertex1  (vertex1),
        .vertex2  (vertex2),
        .tag      (tag)
    );

endmodule

//--- hw/tri_mem_ctrl.sv
`timescale 1ns/1ns
`include "tri_mem_macros.svh"

module tri_mem_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         load_req,
    input  tri_mem_load_pkg::load_op_t   load_op,
    input  tri_mem_geom_pkg::vtx_idx_t   load_addr,
    input  tri_mem_load_pkg::load_data_t load_data,
    input  logic                         re,
    input  tri_mem_geom_pkg::tri_id_t    tri_id,
    input  tri_mem_geom_pkg::tag_t       idx_q,
    output logic                         load_ack,
    output logic                         rdy,
    output logic                         idx_we,
    output logic [$clog2(`TRI_NUM_TRIANGLE)+1:0] idx_addr,
    output tri_mem_geom_pkg::tag_t       idx_wdata,
    output logic                         vtx_we,
    output tri_mem_geom_pkg::vtx_idx_t   vtx_addr,
    output tri_mem_geom_pkg::vertex_t    vtx_wdata,
    output logic                         cap_en,
    output tri_mem_geom_pkg::buf_sel_t   cap_slot,
    output logic [1:0]                   cap_lane,
    output logic                         promote
);

    import tri_mem_load_pkg::*;
    import tri_mem_geom_pkg::*;

    load_state_t ld_state, ld_next;
    rd_state_t   rd_state, rd_next;
    tri_id_t     last_id, pf_id, req_id, id_sel, op_id;
    vtx_idx_t    vaddr_q;
    logic        pf_valid, pf_done, rd_pend;
    logic        in_pf, rd_quiet, ld_go, ld_writing, hit, rd_start, pf_start, pf_abort;
    logic [1:0]  ld_word, rd_word;

    assign in_pf    = rd_state inside {PF_IDX0, PF_IDX1, PF_IDX2, PF_IDX3, PF_VTX_LAST};
    assign rd_quiet = (rd_state == RD_IDLE) || (rd_state == RD_DONE) || in_pf;
    // core reads win over a load waiting in the same cycle
    assign ld_go    = (ld_state == LD_IDLE) && load_req && rd_quiet && !re && !rd_pend
                      && !promote;
    assign id_sel   = re ? tri_id : req_id;
    assign hit      = pf_valid && pf_done && (id_sel == pf_id);
    assign rd_start = (re || rd_pend) && (ld_state == LD_IDLE)
                      && ((rd_state == RD_IDLE) || (rd_state == RD_DONE));
    assign pf_start = (rd_state == RD_DONE) && !re && !rd_pend && !promote && !load_req
                      && (ld_state == LD_IDLE) && !(pf_valid && (pf_id == last_id + 1'b1));
    assign pf_abort = in_pf && (ld_go || (re && (tri_id != pf_id)));

    // load sequencing
    always_comb begin
        ld_next = ld_state;
        case (ld_state)
            LD_IDLE: if (ld_go) ld_next = (load_op == LOAD_INDEX) ? LD_W0 : LD_W3;
            LD_W0:   ld_next = LD_W1;
            LD_W1:   ld_next = LD_W2;
            LD_W2:   ld_next = LD_W3;
            LD_W3:   ld_next = LD_ACK;
            LD_ACK:  if (!load_req) ld_next = LD_IDLE;
            default: ld_next = LD_IDLE;
        endcase
    end

    always_comb begin
        case (ld_state)
            LD_W0:   ld_word = 2'd0;
            LD_W1:   ld_word = 2'd1;
            LD_W2:   ld_word = 2'd2;
            default: ld_word = 2'd3;
        endcase
    end

    assign ld_writing = ld_state inside {LD_W0, LD_W1, LD_W2, LD_W3};
    assign load_ack   = (ld_state == LD_ACK);
    assign idx_we     = ld_writing && (load_op == LOAD_INDEX);
    // word 0 is the high lane
    assign idx_wdata  = load_data[(2'd3 - ld_word) * `TRI_WORD_W +: `TRI_WORD_W];
    assign vtx_we     = (ld_state == LD_W3) && (load_op == LOAD_VERTEX);
    // flag lane dropped
    assign vtx_wdata  = load_data[`TRI_LOAD_W-1 -: 3*`TRI_WORD_W];

    // read and prefetch sequence, both share the same pipeline
    always_comb begin
        rd_next  = rd_state;
        rd_word  = 2'd0;
        cap_en   = 1'b0;
        cap_lane = 2'd0;
        case (rd_state)
            RD_IDLE, RD_DONE: begin
                if (rd_start && !hit)
                    rd_next = RD_IDX0;
                else if (pf_start)
                    rd_next = PF_IDX0;
            end
            RD_IDX0, PF_IDX0: begin
                rd_word = 2'd1;
                rd_next = in_pf ? PF_IDX1 : RD_IDX1;
            end
            RD_IDX1, PF_IDX1: begin
                rd_word = 2'd2;
                cap_en  = 1'b1;
                rd_next = in_pf ? PF_IDX2 : RD_IDX2;
            end
            RD_IDX2, PF_IDX2: begin
                rd_word  = 2'd3;
                cap_en   = 1'b1;
                cap_lane = 2'd1;
                rd_next  = in_pf ? PF_IDX3 : RD_IDX3;
            end
            RD_IDX3, PF_IDX3: begin
                // tag word is out, vertex 2 is re-read from the held address
                rd_word  = 2'd3;
                cap_en   = 1'b1;
                cap_lane = 2'd3;
                rd_next  = in_pf ? PF_VTX_LAST : RD_VTX_LAST;
            end
            RD_VTX_LAST, PF_VTX_LAST: begin
                cap_en   = 1'b1;
                cap_lane = 2'd2;
                rd_next  = RD_DONE;
            end
            default: rd_next = RD_IDLE;
        endcase
        if (pf_abort)
            rd_next = RD_DONE;
    end

    always_comb begin
        if ((rd_state == RD_IDLE) || (rd_state == RD_DONE))
            op_id = rd_start ? id_sel : last_id + 1'b1;
        else if (in_pf)
            op_id = pf_id;
        else
            op_id = last_id;
    end

    assign cap_slot = in_pf ? BUF_PF : BUF_CUR;
    assign idx_addr = ld_writing ? {load_addr[$bits(tri_id_t)-1:0], ld_word} : {op_id, rd_word};

    always_comb begin
        case (rd_state)
            RD_IDX0, RD_IDX1, RD_IDX2, PF_IDX0, PF_IDX1, PF_IDX2:
                vtx_addr = idx_q[$bits(vtx_idx_t)-1:0];
            RD_IDX3, PF_IDX3:
                vtx_addr = vaddr_q;
            default:
                vtx_addr = load_addr;
        endcase
    end

    always_ff @(posedge clk) begin
        vaddr_q <= vtx_addr;
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            ld_state <= LD_IDLE;
            rd_state <= RD_IDLE;
            rdy      <= 1'b0;
            promote  <= 1'b0;
            rd_pend  <= 1'b0;
            req_id   <= '0;
            last_id  <= '0;
        end else begin
            ld_state <= ld_next;
            rd_state <= rd_next;
            promote  <= rd_start && hit;
            if (re)
                req_id <= tri_id;
            if (rd_start) begin
                rd_pend <= 1'b0;
                last_id <= id_sel;
            end else if (re) begin
                rd_pend <= 1'b1;
            end
            if (re)
                rdy <= 1'b0;
            else if (promote || (rd_state == RD_VTX_LAST))
                rdy <= 1'b1;
        end
    end

    // prefetch tracker
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            pf_id    <= '0;
            pf_valid <= 1'b0;
            pf_done  <= 1'b0;
        end else if (ld_go || pf_abort) begin
            pf_valid <= 1'b0;
            pf_done  <= 1'b0;
        end else if (pf_start) begin
            pf_id    <= last_id + 1'b1;
            pf_valid <= 1'b1;
            pf_done  <= 1'b0;
        end else if (rd_state == PF_VTX_LAST) begin
            pf_done  <= 1'b1;
        end
    end

endmodule

//--- hw/tri_out_buf.sv
`timescale 1ns/1ns

module tri_out_buf (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cap_en,
    input  tri_mem_geom_pkg::buf_sel_t cap_slot,
    input  logic [1:0]                 cap_lane,
    input  logic                       promote,
    input  tri_mem_geom_pkg::vertex_t  vtx_q,
    input  tri_mem_geom_pkg::tag_t     idx_q,
    output tri_mem_geom_pkg::vertex_t  vertex0,
    output tri_mem_geom_pkg::vertex_t  vertex1,
    output tri_mem_geom_pkg::vertex_t  vertex2,
    output tri_mem_geom_pkg::tag_t     tag
);

    import tri_mem_geom_pkg::*;

    vertex_t cur_v [3];
    vertex_t pf_v  [3];
    tag_t    cur_tag, pf_tag;

    // current slot drives the outputs, zero after reset
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            cur_v   <= '{default: '0};
            cur_tag <= '0;
        end else if (promote) begin
            cur_v   <= pf_v;
            cur_tag <= pf_tag;
        end else if (cap_en && (cap_slot == BUF_CUR)) begin
            if (cap_lane == 2'd3)
                cur_tag <= idx_q;
            else
                cur_v[cap_lane] <= vtx_q;
        end
    end

    always_ff @(posedge clk) begin
        if (cap_en && (cap_slot == BUF_PF)) begin
            if (cap_lane == 2'd3)
                pf_tag <= idx_q;
            else
                pf_v[cap_lane] <= vtx_q;
        end
    end

    assign vertex0 = cur_v[0];
    assign vertex1 = cur_v[1];
    assign vertex2 = cur_v[2];
    assign tag     = cur_tag;

endmodule

//--- hw/vertex_ram.sv
`timescale 1ns/1ns
`include "tri_mem_macros.svh"

module vertex_ram (
    input  logic                       clk,
    input  logic                       we,
    input  tri_mem_geom_pkg::vtx_idx_t addr,
    input  tri_mem_geom_pkg::vertex_t  wdata,
    output tri_mem_geom_pkg::vertex_t  q
);

    logic [`TRI_WORD_W-1:0] x_mem [`TRI_NUM_VERTEX];
    logic [`TRI_WORD_W-1:0] y_mem [`TRI_NUM_VERTEX];
    logic [`TRI_WORD_W-1:0] z_mem [`TRI_NUM_VERTEX];
    logic [`TRI_WORD_W-1:0] x_q, y_q, z_q;

    // banks split by lane so a flag bank can be added later
    always_ff @(posedge clk) begin
        x_q <= x_mem[addr];
        y_q <= y_mem[addr];
        z_q <= z_mem[addr];
        if (we) begin
            x_mem[addr] <= wdata[3*`TRI_WORD_W-1 -: `TRI_WORD_W];
            y_mem[addr] <= wdata[2*`TRI_WORD_W-1 -: `TRI_WORD_W];
            z_mem[addr] <= wdata[`TRI_WORD_W-1 -: `TRI_WORD_W];
        end
    end

    assign q = {x_q, y_q, z_q};

endmodule

//--- hw/tri_index_ram.sv
`timescale 1ns/1ns
`include "tri_mem_macros.svh"

module tri_index_ram (
    input  logic                                 clk,
    input  logic                                 we,
    input  logic [$clog2(`TRI_NUM_TRIANGLE)+1:0] addr,
    input  logic [`TRI_WORD_W-1:0]               wdata,
    output logic [`TRI_WORD_W-1:0]               q
);

    localparam int DEPTH = `TRI_NUM_TRIANGLE * 4;

    // four words per triangle: v0 idx, v1 idx, v2 idx, tag
    logic [`TRI_WORD_W-1:0] mem [DEPTH];

    // read-first, q shows the old word during a write
    always_ff @(posedge clk) begin
        q <= mem[addr];
        if (we)
            mem[addr] <= wdata;
    end

endmodule

//--- hw/tri_mem_geom_pkg.sv
package tri_mem_geom_pkg;

    `include "tri_mem_macros.svh"

    typedef logic [$clog2(`TRI_NUM_TRIANGLE)-1:0] tri_id_t;

    typedef logic [$clog2(`TRI_NUM_VERTEX)-1:0] vtx_idx_t;

    // x, y, z from high to low
    typedef logic [3*`TRI_WORD_W-1:0] vertex_t;

    typedef logic [`TRI_WORD_W-1:0] tag_t;

    // state names say which index word sits on the index RAM output
    typedef enum logic [3:0] {
        RD_IDLE,
        RD_IDX0,
        RD_IDX1,
        RD_IDX2,
        RD_IDX3,
        RD_VTX_LAST,
        RD_DONE,
        PF_IDX0,
        PF_IDX1,
        PF_IDX2,
        PF_IDX3,
        PF_VTX_LAST
    } rd_state_t;

    // slot of the output buffer being written
    typedef enum logic {
        BUF_CUR,
        BUF_PF
    } buf_sel_t;

endpackage

//--- hw/tri_mem_load_pkg.sv
package tri_mem_load_pkg;

    `include "tri_mem_macros.svh"

    // what a load write carries
    typedef enum logic {
        LOAD_INDEX,
        LOAD_VERTEX
    } load_op_t;

    // index: v0 idx, v1 idx, v2 idx, tag from high lane to low
    // vertex: x, y, z, flag from high lane to low
    typedef logic [`TRI_LOAD_W-1:0] load_data_t;

    // index load walks W0..W3, vertex load jumps to W3
    typedef enum logic [2:0] {
        LD_IDLE,
        LD_W0,
        LD_W1,
        LD_W2,
        LD_W3,
        LD_ACK
    } load_state_t;

endpackage

//--- include/tri_mem_macros.svh
`ifndef TRI_MEM_MACROS_SVH
`define TRI_MEM_MACROS_SVH

// triangles held in the index memory
`define TRI_NUM_TRIANGLE 512

// vertices held in the coordinate banks
`define TRI_NUM_VERTEX 1024

// one coordinate, one vertex index or one tag
`define TRI_WORD_W 32

// load port word, four lanes
`define TRI_LOAD_W 128

`endif
